// ==== include/modexp_consts.svh ====
/* modular exponentiator constants */
`ifndef MODEXP_CONSTS_SVH
`define MODEXP_CONSTS_SVH

`define WORD_WIDTH 16                              // bits per word
`define NUM_WORDS 4                                // words per operand
`define EXP_BITS (`WORD_WIDTH * `NUM_WORDS)        // full operand width

// index widths
`define WORD_IDX_W $clog2(`NUM_WORDS)
`define BIT_IDX_W $clog2(`EXP_BITS)

`endif

// ==== hw/modexp_types_pkg.sv ====
/* operand data types */
`include "modexp_consts.svh"

package modexp_types_pkg;

    typedef logic [`WORD_WIDTH-1:0]   word_t;
    typedef logic [2*`WORD_WIDTH-1:0] dword_t;     // mac result, carry in upper half
    typedef logic [`WORD_IDX_W-1:0]   word_idx_t;
    typedef logic [`EXP_BITS-1:0]     exp_t;
    typedef logic [`BIT_IDX_W-1:0]    bit_idx_t;

    // one word of every operand, per load cycle
    typedef struct packed {
        word_t m;
        word_t e;
        word_t n;
        word_t r;       // R mod n
        word_t t;       // R^2 mod n
    } load_words_t;

    // operand words returned to the multiplier
    typedef struct packed {
        word_t a_word;
        word_t b_word;
        word_t n_word;
    } mont_words_t;

endpackage

// ==== hw/modexp_state_pkg.sv ====
/* FSM state encodings */
package modexp_state_pkg;

    typedef enum logic [3:0] {
        ctrl_idle, ctrl_load, ctrl_wait_compute, ctrl_calc_m_bar, ctrl_square,
        ctrl_multiply, ctrl_finish, ctrl_complete, ctrl_output
    } ctrl_state_t;

    typedef enum logic [2:0] {
        mont_idle, mont_mul_row, mont_row_carry, mont_calc_q, mont_reduce_row,
        mont_shift_carry, mont_top_carry, mont_write_back
    } mont_state_t;

    // operand a of a product
    typedef enum logic [1:0] {a_sel_msg, a_sel_c_bar, a_sel_one} mont_a_sel_t;

    // operand b of a product
    typedef enum logic [1:0] {b_sel_t, b_sel_c_bar, b_sel_m_bar} mont_b_sel_t;

endpackage

// ==== hw/mont_mul.sv ====
/* CIOS Montgomery multiplier */
`timescale 1ns/1ps
`include "modexp_consts.svh"

module mont_mul (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,
    input  modexp_types_pkg::word_t       n0_inv,
    input  modexp_types_pkg::mont_words_t words,
    output modexp_types_pkg::word_idx_t   a_idx,
    output modexp_types_pkg::word_idx_t   b_idx,
    output logic                          res_we,
    output modexp_types_pkg::word_idx_t   res_idx,
    output modexp_types_pkg::word_t       res_word,
    output logic                          done
);
    import modexp_types_pkg::*;
    import modexp_state_pkg::*;

    localparam word_idx_t last_idx = word_idx_t'(`NUM_WORDS - 1);

    mont_state_t          state;
    word_idx_t            i;                       // row, word of a
    word_idx_t            j;                       // column
    logic                 ph;                      // 0 issue, 1 capture
    word_t                v [`NUM_WORDS + 2];      // accumulator
    word_t                carry;
    word_t                q;                       // row quotient
    dword_t               mac_q;
    word_t                mac_x;
    word_t                mac_y;
    word_t                mac_z;
    word_t                mac_c;
    word_t                mac_lo;
    word_t                mac_hi;
    word_t                sub_word;
    logic                 borrow;
    logic [`WORD_WIDTH:0] wb_diff;

    assign mac_lo = mac_q[`WORD_WIDTH-1:0];
    assign mac_hi = mac_q[2*`WORD_WIDTH-1:`WORD_WIDTH];

    // mac operands by step
    always_comb begin
        mac_x = '0;
        mac_y = '0;
        mac_z = '0;
        mac_c = '0;
        case (state)
            mont_mul_row: begin
                mac_x = words.a_word;
                mac_y = words.b_word;
                mac_z = v[j];
                mac_c = carry;
            end
            mont_row_carry, mont_shift_carry: begin
                mac_z = v[`NUM_WORDS];
                mac_c = carry;
            end
            mont_calc_q: begin
                mac_x = v[0];
                mac_y = n0_inv;
            end
            mont_reduce_row: begin
                mac_x = q;
                mac_y = words.n_word;
                mac_z = v[j];
                mac_c = carry;
            end
            mont_top_carry: begin
                mac_z = v[`NUM_WORDS + 1];
                mac_c = carry;
            end
            default: ;
        endcase
    end

    // a product at or above R is brought back under R by subtracting n once
    assign sub_word = (v[`NUM_WORDS] != '0) ? words.n_word : '0;
    assign wb_diff  = {1'b0, v[j]} - {1'b0, sub_word} - {{`WORD_WIDTH{1'b0}}, borrow};

    assign a_idx    = i;
    assign b_idx    = j;
    assign res_we   = (state == mont_write_back);
    assign res_idx  = j;
    assign res_word = wb_diff[`WORD_WIDTH-1:0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= mont_idle;
            i     <= '0;
            j     <= '0;
            ph    <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            ph   <= (state != mont_idle && state != mont_write_back) ? ~ph : 1'b0;
            case (state)
                mont_idle: if (start) begin
                    state <= mont_mul_row;
                    i     <= '0;
                    j     <= '0;
                end
                mont_mul_row, mont_reduce_row: if (ph) begin
                    if (j == last_idx) begin
                        j     <= '0;
                        state <= (state == mont_mul_row) ? mont_row_carry : mont_shift_carry;
                    end else begin
                        j <= j + 1'b1;
                    end
                end
                mont_row_carry:   if (ph) state <= mont_calc_q;
                mont_calc_q:      if (ph) state <= mont_reduce_row;
                mont_shift_carry: if (ph) state <= mont_top_carry;
                mont_top_carry: if (ph) begin
                    if (i == last_idx) begin
                        state <= mont_write_back;
                    end else begin
                        i     <= i + 1'b1;
                        state <= mont_mul_row;
                    end
                end
                mont_write_back: begin
                    if (j == last_idx) begin
                        j     <= '0;
                        state <= mont_idle;
                        done  <= 1'b1;
                    end else begin
                        j <= j + 1'b1;
                    end
                end
                default: state <= mont_idle;
            endcase
        end
    end

    // datapath, issue then capture
    always_ff @(posedge clk) begin
        if (state == mont_idle && start) begin
            for (int k = 0; k < `NUM_WORDS + 2; k++) begin
                v[k] <= '0;
            end
            carry <= '0;
        end
        if (!ph) begin
            mac_q <= dword_t'(mac_x) * dword_t'(mac_y) + dword_t'(mac_z) + dword_t'(mac_c);
        end else begin
            case (state)
                mont_mul_row: begin
                    v[j]  <= mac_lo;
                    carry <= mac_hi;
                end
                mont_row_carry: begin
                    v[`NUM_WORDS]     <= mac_lo;
                    v[`NUM_WORDS + 1] <= mac_hi;
                end
                mont_calc_q: begin
                    q     <= mac_lo;
                    carry <= '0;
                end
                mont_reduce_row: begin
                    if (j != '0) begin
                        v[j - 1'b1] <= mac_lo;     // shift down one word
                    end
                    carry <= mac_hi;
                end
                mont_shift_carry: begin
                    v[`NUM_WORDS - 1] <= mac_lo;
                    carry             <= mac_hi;
                end
                mont_top_carry: begin
                    v[`NUM_WORDS] <= mac_lo;
                    carry         <= '0;           // next row starts clean
                end
                default: ;
            endcase
        end
        borrow <= (state == mont_write_back) ? wb_diff[`WORD_WIDTH] : 1'b0;
    end

    a_start_idle: assert property (@(posedge clk) disable iff (reset)
        start |-> state == mont_idle);

endmodule

// ==== hw/exp_bit_scanner.sv ====
/* exponent bit scanner */
`timescale 1ns/1ps
`include "modexp_consts.svh"

module exp_bit_scanner (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        e_we,
    input  modexp_types_pkg::word_idx_t e_idx,
    input  modexp_types_pkg::word_t     e_word,
    input  logic                        seek,
    input  logic                        advance,
    output logic                        bit_ready,
    output logic                        exp_bit,
    output logic                        exp_last,
    output logic                        exp_zero
);
    import modexp_types_pkg::*;

    exp_t     e_reg;
    bit_idx_t pos;
    logic     seeking;

    always_ff @(posedge clk) begin
        if (e_we) begin
            e_reg[e_idx * `WORD_WIDTH +: `WORD_WIDTH] <= e_word;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pos       <= '0;
            seeking   <= 1'b0;
            bit_ready <= 1'b0;
            exp_zero  <= 1'b0;
        end else if (seek) begin
            pos       <= bit_idx_t'(`EXP_BITS - 1);  // start from the top
            seeking   <= 1'b1;
            bit_ready <= 1'b0;
            exp_zero  <= 1'b0;
        end else if (seeking) begin
            if (e_reg[pos]) begin
                seeking   <= 1'b0;
                bit_ready <= 1'b1;
            end else if (pos == '0) begin
                seeking   <= 1'b0;                   // no ones at all
                bit_ready <= 1'b1;
                exp_zero  <= 1'b1;
            end else begin
                pos <= pos - 1'b1;
            end
        end else if (advance && pos != '0) begin
            pos <= pos - 1'b1;
        end
    end

    assign exp_bit  = e_reg[pos];
    assign exp_last = (pos == '0);

    a_advance_ready: assert property (@(posedge clk) disable iff (reset)
        advance |-> bit_ready);

endmodule

// ==== hw/modexp_ctrl.sv ====
/* exponentiation controller */
`timescale 1ns/1ps
`include "modexp_consts.svh"

module modexp_ctrl (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start_load,
    input  modexp_types_pkg::load_words_t in_words,
    input  logic                          start_compute,
    input  logic                          get_result,
    input  logic                          bit_ready,
    input  logic                          exp_bit,
    input  logic                          exp_last,
    input  logic                          exp_zero,
    input  modexp_types_pkg::word_idx_t   a_idx,
    input  modexp_types_pkg::word_idx_t   b_idx,
    input  logic                          wb_we,
    input  modexp_types_pkg::word_idx_t   wb_idx,
    input  modexp_types_pkg::word_t       wb_word,
    input  logic                          mont_done,
    output logic                          e_we,
    output modexp_types_pkg::word_idx_t   e_idx,
    output modexp_types_pkg::word_t       e_word,
    output logic                          seek,
    output logic                          advance,
    output logic                          mont_start,
    output modexp_types_pkg::mont_words_t words,
    output logic                          result_ready,
    output logic                          res_valid,
    output modexp_types_pkg::word_t       res_out
);
    import modexp_types_pkg::*;
    import modexp_state_pkg::*;

    localparam word_idx_t last_idx = word_idx_t'(`NUM_WORDS - 1);

    ctrl_state_t state;
    word_idx_t   cnt;                      // load and unload word count
    logic        m_bar_done;
    mont_a_sel_t a_sel;
    mont_b_sel_t b_sel;
    word_t       m_store [`NUM_WORDS];
    word_t       n_store [`NUM_WORDS];
    word_t       r_store [`NUM_WORDS];
    word_t       t_store [`NUM_WORDS];
    word_t       m_bar   [`NUM_WORDS];
    word_t       c_bar   [`NUM_WORDS];

    assign e_we         = (state == ctrl_load);
    assign e_idx        = cnt;
    assign e_word       = in_words.e;
    assign result_ready = (state == ctrl_complete) || (state == ctrl_output);

    always_comb begin
        a_sel = (state == ctrl_calc_m_bar) ? a_sel_msg :
                (state == ctrl_finish)     ? a_sel_one : a_sel_c_bar;
        b_sel = (state == ctrl_calc_m_bar) ? b_sel_t :
                (state == ctrl_multiply)   ? b_sel_m_bar : b_sel_c_bar;
    end

    // operand words for the multiplier
    always_comb begin
        case (a_sel)
            a_sel_msg:   words.a_word = m_store[a_idx];
            a_sel_c_bar: words.a_word = c_bar[a_idx];
            default:     words.a_word = (a_idx == '0) ? word_t'(1) : '0;
        endcase
        case (b_sel)
            b_sel_t:     words.b_word = t_store[b_idx];
            b_sel_c_bar: words.b_word = c_bar[b_idx];
            default:     words.b_word = m_bar[b_idx];
        endcase
        words.n_word = n_store[b_idx];
    end

    always_ff @(posedge clk) begin
        if (state == ctrl_load) begin
            m_store[cnt] <= in_words.m;
            n_store[cnt] <= in_words.n;
            r_store[cnt] <= in_words.r;
            t_store[cnt] <= in_words.t;
        end
        if (state == ctrl_wait_compute && start_compute) begin
            c_bar <= r_store;                 // one in Montgomery form
        end else if (wb_we) begin
            if (state == ctrl_calc_m_bar) begin
                m_bar[wb_idx] <= wb_word;
            end else begin
                c_bar[wb_idx] <= wb_word;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= ctrl_idle;
            cnt        <= '0;
            m_bar_done <= 1'b0;
            seek       <= 1'b0;
            advance    <= 1'b0;
            mont_start <= 1'b0;
            res_valid  <= 1'b0;
            res_out    <= '0;
        end else begin
            seek       <= 1'b0;
            advance    <= 1'b0;
            mont_start <= 1'b0;
            res_valid  <= 1'b0;
            res_out    <= '0;
            case (state)
                ctrl_idle: if (start_load) begin
                    state <= ctrl_load;
                    cnt   <= '0;
                end
                ctrl_load: begin
                    if (cnt == last_idx) begin
                        cnt   <= '0;
                        state <= ctrl_wait_compute;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ctrl_wait_compute: if (start_compute) begin
                    state      <= ctrl_calc_m_bar;
                    m_bar_done <= 1'b0;
                    seek       <= 1'b1;          // scan e while m_bar forms
                    mont_start <= 1'b1;
                end
                ctrl_calc_m_bar: begin
                    if (mont_done) begin
                        m_bar_done <= 1'b1;
                    end
                    if (m_bar_done && bit_ready) begin
                        state      <= exp_zero ? ctrl_finish : ctrl_square;
                        mont_start <= 1'b1;
                    end
                end
                ctrl_square: if (mont_done) begin
                    mont_start <= 1'b1;
                    if (exp_bit) begin
                        state <= ctrl_multiply;
                    end else if (exp_last) begin
                        state <= ctrl_finish;
                    end else begin
                        advance <= 1'b1;          // square again on next bit
                    end
                end
                ctrl_multiply: if (mont_done) begin
                    mont_start <= 1'b1;
                    if (exp_last) begin
                        state <= ctrl_finish;
                    end else begin
                        advance <= 1'b1;
                        state   <= ctrl_square;
                    end
                end
                ctrl_finish: if (mont_done) state <= ctrl_complete;
                ctrl_complete: if (get_result) begin
                    state     <= ctrl_output;
                    cnt       <= '0;
                    res_valid <= 1'b1;
                    res_out   <= c_bar[0];
                end
                ctrl_output: begin
                    if (cnt == last_idx) begin
                        cnt   <= '0;
                        state <= ctrl_idle;
                    end else begin
                        cnt       <= cnt + 1'b1;
                        res_valid <= 1'b1;
                        res_out   <= c_bar[cnt + 1'b1];
                    end
                end
                default: state <= ctrl_idle;
            endcase
        end
    end

    a_valid_in_output: assert property (@(posedge clk) disable iff (reset)
        res_valid |-> state == ctrl_output && !wb_we);

endmodule

// ==== hw/modexp_top.sv ====
/* modular exponentiator top */
`timescale 1ns/1ps

module modexp_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start_load,
    input  modexp_types_pkg::load_words_t in_words,
    input  modexp_types_pkg::word_t       nprime0,
    input  logic                          start_compute,
    input  logic                          get_result,
    output logic                          result_ready,
    output logic                          res_valid,
    output modexp_types_pkg::word_t       res_out
);
    import modexp_types_pkg::*;

    logic        e_we;
    word_idx_t   e_idx;
    word_t       e_word;
    logic        seek;
    logic        advance;
    logic        bit_ready;
    logic        exp_bit;
    logic        exp_last;
    logic        exp_zero;
    logic        mont_start;
    mont_words_t mont_words;
    word_idx_t   a_idx;
    word_idx_t   b_idx;
    logic        wb_we;
    word_idx_t   wb_idx;
    word_t       wb_word;
    logic        mont_done;

    exp_bit_scanner u_scanner (
        .clk       (clk),
        .reset     (reset),
        .e_we      (e_we),
        .e_idx     (e_idx),
        .e_word    (e_word),
        .seek      (seek),
        .advance   (advance),
        .bit_ready (bit_ready),
        .exp_bit   (exp_bit),
        .exp_last  (exp_last),
        .exp_zero  (exp_zero)
    );

    mont_mul u_mont (
        .clk      (clk),
        .reset    (reset),
        .start    (mont_start),
        .n0_inv   (nprime0),
        .words    (mont_words),
        .a_idx    (a_idx),
        .b_idx    (b_idx),
        .res_we   (wb_we),
        .res_idx  (wb_idx),
        .res_word (wb_word),
        .done     (mont_done)
    );

    modexp_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .start_load    (start_load),
        .in_words      (in_words),
        .start_compute (start_compute),
        .get_result    (get_result),
        .bit_ready     (bit_ready),
        .exp_bit       (exp_bit),
        .exp_last      (exp_last),
        .exp_zero      (exp_zero),
        .a_idx         (a_idx),
        .b_idx         (b_idx),
        .wb_we         (wb_we),
        .wb_idx        (wb_idx),
        .wb_word       (wb_word),
        .mont_done     (mont_done),
        .e_we          (e_we),
        .e_idx         (e_idx),
        .e_word        (e_word),
        .seek          (seek),
        .advance       (advance),
        .mont_start    (mont_start),
        .words         (mont_words),
        .result_ready  (result_ready),
        .res_valid     (res_valid),
        .res_out       (res_out)
    );

endmodule

// ==== testbench/tb_modexp.sv ====
/* modular exponentiator testbench */
`timescale 1ns/1ps
`include "modexp_consts.svh"

module tb_modexp;
    import modexp_types_pkg::*;

    localparam int mont_latency = `NUM_WORDS * (4 * `NUM_WORDS + 8) + `NUM_WORDS + 1;
    localparam int worst_run    = (2 * `EXP_BITS + 2) * mont_latency + `EXP_BITS;
    localparam int num_runs     = 9;
    localparam int cycle_limit  = num_runs * worst_run + 2000;   // load and unload margin

    logic        clk;
    logic        reset;
    logic        start_load;
    load_words_t in_words;
    word_t       nprime0;
    logic        start_compute;
    logic        get_result;
    logic        result_ready;
    logic        res_valid;
    word_t       res_out;

    integer      seed;
    int          cycles;
    string       wait_name;

    modexp_top UUT (
        .clk           (clk),
        .reset         (reset),
        .start_load    (start_load),
        .in_words      (in_words),
        .nprime0       (nprime0),
        .start_compute (start_compute),
        .get_result    (get_result),
        .result_ready  (result_ready),
        .res_valid     (res_valid),
        .res_out       (res_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog
    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles while waiting for %s", cycles, wait_name);
        $display("Some tests failed");
        $fatal(1, "cycle limit reached");
    end

    task automatic check_word(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, expected);
            $display("Some tests failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, expected);
            $display("Some tests failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    // a * b mod n by shift and add, a below n
    task automatic mod_mul(input exp_t a, input exp_t b, input exp_t n, output exp_t p);
        logic [`EXP_BITS:0] acc;
        acc = '0;
        for (int i = `EXP_BITS - 1; i >= 0; i--) begin
            acc = acc << 1;
            if (acc >= {1'b0, n}) begin
                acc = acc - {1'b0, n};
            end
            if (b[i]) begin
                acc = acc + {1'b0, a};
                if (acc >= {1'b0, n}) begin
                    acc = acc - {1'b0, n};
                end
            end
        end
        p = acc[`EXP_BITS-1:0];
    endtask

    // left to right square and multiply
    task automatic mod_exp(input exp_t m, input exp_t e, input exp_t n, output exp_t p);
        exp_t acc;
        acc = exp_t'(1);
        for (int i = `EXP_BITS - 1; i >= 0; i--) begin
            mod_mul(acc, acc, n, acc);
            if (e[i]) begin
                mod_mul(acc, m, n, acc);
            end
        end
        p = acc;
    endtask

    task automatic mont_params(input exp_t n, output exp_t r, output exp_t t,
                               output word_t np0);
        logic [`EXP_BITS:0] acc;
        word_t              n0;
        word_t              x;
        acc = 1;
        repeat (`EXP_BITS) begin              // R mod n by doubling
            acc = acc << 1;
            if (acc >= {1'b0, n}) begin
                acc = acc - {1'b0, n};
            end
        end
        r = acc[`EXP_BITS-1:0];
        mod_mul(r, r, n, t);
        n0 = n[`WORD_WIDTH-1:0];
        x  = n0;                              // good to 3 bits for odd n
        repeat (6) begin
            x = x * (word_t'(2) - n0 * x);    // newton step doubles precision
        end
        np0 = ~x + 1'b1;
    endtask

    task automatic rand_operand(output exp_t v);
        for (int k = 0; k < `NUM_WORDS; k++) begin
            v[k*`WORD_WIDTH +: `WORD_WIDTH] = word_t'($random(seed));
        end
    endtask

    task automatic load_operands(input exp_t m, input exp_t e, input exp_t n, input exp_t r,
                                 input exp_t t, input word_t np0);
        load_words_t w;
        @(posedge clk);
        start_load <= 1'b1;
        nprime0    <= np0;
        @(posedge clk);
        start_load <= 1'b0;
        for (int k = 0; k < `NUM_WORDS; k++) begin
            w.m = m[k*`WORD_WIDTH +: `WORD_WIDTH];
            w.e = e[k*`WORD_WIDTH +: `WORD_WIDTH];
            w.n = n[k*`WORD_WIDTH +: `WORD_WIDTH];
            w.r = r[k*`WORD_WIDTH +: `WORD_WIDTH];
            w.t = t[k*`WORD_WIDTH +: `WORD_WIDTH];
            in_words <= w;
            @(posedge clk);                   // word captured here
        end
        in_words <= '0;
    endtask

    task automatic compute_and_wait();
        @(posedge clk);
        start_compute <= 1'b1;
        @(posedge clk);
        start_compute <= 1'b0;
        wait_name = "result_ready";
        @(negedge clk);
        while (!result_ready) begin
            @(negedge clk);
        end
    endtask

    task automatic unload_result(output exp_t got);
        got = '0;
        @(posedge clk);
        get_result <= 1'b1;
        @(posedge clk);
        get_result <= 1'b0;
        wait_name = "res_valid";
        @(negedge clk);
        while (!res_valid) begin
            @(negedge clk);
        end
        for (int k = 0; k < `NUM_WORDS; k++) begin
            check_flag("res_valid", res_valid, 1'b1);
            check_flag("result_ready", result_ready, 1'b1);
            got[k*`WORD_WIDTH +: `WORD_WIDTH] = res_out;
            @(negedge clk);
        end
        check_flag("res_valid", res_valid, 1'b0);   // exactly NUM_WORDS strobes
        check_flag("result_ready", result_ready, 1'b0);
    endtask

    task automatic run_case(input string label, input exp_t m, input exp_t e, input exp_t n);
        exp_t  r;
        exp_t  t;
        word_t np0;
        exp_t  expected;
        exp_t  got;
        mont_params(n, r, t, np0);
        mod_exp(m, e, n, expected);
        load_operands(m, e, n, r, t, np0);
        compute_and_wait();
        unload_result(got);
        for (int k = 0; k < `NUM_WORDS; k++) begin
            check_word($sformatf("res_out word %0d (%s)", k, label),
                       got[k*`WORD_WIDTH +: `WORD_WIDTH],
                       expected[k*`WORD_WIDTH +: `WORD_WIDTH]);
        end
        $display("case %s: result 0x%h", label, got);
    endtask

    task automatic random_case(input string label, input logic fixed_e, input exp_t e_val);
        exp_t n;
        exp_t m;
        exp_t e;
        rand_operand(n);
        n[`EXP_BITS-1] = 1'b1;                // full width
        n[0]           = 1'b1;                // odd
        rand_operand(m);
        m = m % n;
        rand_operand(e);
        if (fixed_e) begin
            e = e_val;
        end else if (e == '0) begin
            e = exp_t'(1);
        end
        run_case(label, m, e, n);
    endtask

    // strobes outside their states must be ignored
    task automatic stray_strobes();
        @(posedge clk);
        start_compute <= 1'b1;
        @(posedge clk);
        start_compute <= 1'b0;
        get_result    <= 1'b1;
        @(posedge clk);
        get_result <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_flag("result_ready", result_ready, 1'b0);
            check_flag("res_valid", res_valid, 1'b0);
        end
        random_case("after stray strobes", 1'b0, '0);
    endtask

    initial begin
        seed          = 32'hccc7_7ce7;
        wait_name     = "reset";
        reset         = 1'b1;
        start_load    = 1'b0;
        in_words      = '0;
        nprime0       = '0;
        start_compute = 1'b0;
        get_result    = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag("result_ready", result_ready, 1'b0);
        check_flag("res_valid", res_valid, 1'b0);
        check_word("res_out", res_out, '0);

        run_case("small", exp_t'(5), exp_t'(3), exp_t'(64'hf123_4567_89ab_cdef));
        random_case("random 0", 1'b0, '0);
        random_case("random 1", 1'b0, '0);
        random_case("random 2", 1'b0, '0);
        random_case("exponent zero", 1'b1, '0);
        random_case("exponent one", 1'b1, exp_t'(1));
        random_case("back to back a", 1'b0, '0);
        random_case("back to back b", 1'b0, '0);
        stray_strobes();

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== modexp.f ====
+incdir+include
hw/modexp_types_pkg.sv
hw/modexp_state_pkg.sv
hw/mont_mul.sv
hw/exp_bit_scanner.sv
hw/modexp_ctrl.sv
hw/modexp_top.sv
testbench/tb_modexp.sv

// ==== Makefile ====
# Verilator build for the modular exponentiator

VERILATOR ?= verilator
FILELIST  ?= modexp.f
TB_TOP    ?= tb_modexp
RTL_TOP   ?= modexp_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  := Some tests failed

RTL_SRCS := $(filter hw/%,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only +incdir+include $(RTL_SRCS) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "All tests passed" $(LOG) || (echo "simulation ended without passing"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
